//--- hw/gb_sound_defs.svh
`ifndef GB_SOUND_DEFS_SVH
`define GB_SOUND_DEFS_SVH

// cpu side address map of the sound unit
`define SND_CH_BASE     16'hFF10
`define SND_CH_STRIDE   5
`define SND_NUM_CH      4
`define SND_WAVE_BASE   16'hFF30
`define SND_WAVE_BYTES  16
`define SND_CTRL_BASE   16'hFF24
`define SND_NUM_CTRL    3

// bus and field widths
`define SND_ADDR_W      16
`define SND_BYTE_W      8
`define SND_FREQ_W      11

`endif

//--- hw/snd_field_pkg.sv
`default_nettype none

`include "gb_sound_defs.svh"

package snd_field_pkg;

   typedef logic [`SND_BYTE_W-1:0] reg_byte_t;    // one NRxx byte
   typedef logic [`SND_ADDR_W-1:0] bus_addr_t;    // cpu address
   typedef logic [`SND_FREQ_W-1:0] freq_t;        // x in 131072/(2048-x)
   typedef logic [5:0]             length6_t;     // t1 0..63
   typedef logic [7:0]             length8_t;     // t1 0..255, wave channel
   typedef logic [3:0]             volume_t;      // envelope start volume
   typedef logic [2:0]             steps_t;       // sweep or envelope count
   typedef logic [1:0]             duty_t;        // 12.5/25/50/75 percent
   typedef logic [1:0]             out_level_t;   // mute, 100, 50, 25 percent
   typedef logic [2:0]             master_vol_t;  // terminal volume 0..7

   // 32 nibble samples, sample zero in the top nibble
   typedef logic [`SND_WAVE_BYTES*`SND_BYTE_W-1:0] wave_vec_t;

endpackage

`default_nettype wire

//--- hw/snd_map_pkg.sv
`default_nettype none

`include "gb_sound_defs.svh"

package snd_map_pkg;

   typedef logic [`SND_NUM_CH-1:0]     ch_sel_t;    // one-hot channel window
   typedef logic [`SND_CH_STRIDE-1:0]  bank_be_t;   // one-hot byte in window
   typedef logic [`SND_WAVE_BYTES-1:0] wave_sel_t;  // one-hot wave byte
   typedef logic [`SND_NUM_CTRL-1:0]   ctrl_sel_t;  // NR50, NR51, NR52

   // byte position inside a channel window, NRx0 .. NRx4
   typedef enum logic [2:0] {
      OFS_NRX0 = 3'd0,   // sweep, or wave on/off
      OFS_NRX1 = 3'd1,   // duty and length
      OFS_NRX2 = 3'd2,   // envelope, or wave level
      OFS_NRX3 = 3'd3,   // freq lo, or noise polynomial
      OFS_NRX4 = 3'd4    // freq hi and control
   } bank_offset_e;

   typedef enum logic [1:0] {
      CTRL_NR50 = 2'd0,  // vin and terminal volume
      CTRL_NR51 = 2'd1,  // terminal routing
      CTRL_NR52 = 2'd2   // master enable and on flags
   } ctrl_reg_e;

endpackage

`default_nettype wire

//--- hw/snd_addr_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "gb_sound_defs.svh"

module snd_addr_decode (
   input  snd_field_pkg::bus_addr_t reg_addr,
   input  logic                     reg_w_enable,
   output snd_map_pkg::ch_sel_t     ch_sel,
   output snd_map_pkg::bank_be_t    bank_be,
   output snd_map_pkg::wave_sel_t   wave_sel,
   output snd_map_pkg::ctrl_sel_t   ctrl_sel
);
   import snd_field_pkg::*;
   import snd_map_pkg::*;

   bus_addr_t    ch_rel;    // offset from FF10, wraps when below
   bus_addr_t    wave_rel;  // offset from FF30
   bus_addr_t    ctrl_rel;  // offset from FF24
   bus_addr_t    win_rel;   // offset inside the hit window
   bank_offset_e ofs;

   assign ch_rel   = reg_addr - `SND_CH_BASE;
   assign wave_rel = reg_addr - `SND_WAVE_BASE;
   assign ctrl_rel = reg_addr - `SND_CTRL_BASE;

   always_comb begin
      ch_sel   = '0;
      bank_be  = '0;
      wave_sel = '0;
      ctrl_sel = '0;
      win_rel  = '0;
      ofs      = OFS_NRX0;
      if (reg_w_enable) begin
         if (ch_rel < `SND_CH_STRIDE * `SND_NUM_CH) begin  // FF10..FF23
            for (int i = 0; i < `SND_NUM_CH; i++) begin
               if (ch_rel >= bus_addr_t'(i * `SND_CH_STRIDE) &&
                   ch_rel <  bus_addr_t'((i + 1) * `SND_CH_STRIDE)) begin
                  ch_sel[i] = 1'b1;
                  win_rel   = ch_rel - bus_addr_t'(i * `SND_CH_STRIDE);
               end
            end
            ofs          = bank_offset_e'(win_rel[2:0]);  // 0..4 only
            bank_be[ofs] = 1'b1;
         end else if (wave_rel < `SND_WAVE_BYTES) begin   // FF30..FF3F
            wave_sel[wave_rel[3:0]] = 1'b1;
         end else if (ctrl_rel < `SND_NUM_CTRL) begin     // FF24..FF26
            ctrl_sel[ctrl_rel[1:0]] = 1'b1;
         end
         // anything else falls through, write dropped
      end
   end

endmodule

`default_nettype wire

//--- hw/snd_channel_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "gb_sound_defs.svh"

module snd_channel_bank (
   input  logic                                              ac97_bitclk,
   input  logic                                              reset,
   input  logic                                              ch_en,
   input  snd_map_pkg::bank_be_t                             bank_be,
   input  snd_field_pkg::reg_byte_t                          reg_data,
   output snd_field_pkg::reg_byte_t [`SND_CH_STRIDE-1:0]     bank_bytes
);

   // five NRxx bytes of one window, stored as written
   always_ff @(posedge ac97_bitclk or posedge reset) begin
      if (reset) begin
         bank_bytes <= '0;
      end else if (ch_en) begin                  // this window hit
         for (int i = 0; i < `SND_CH_STRIDE; i++) begin
            if (bank_be[i])
               bank_bytes[i] <= reg_data;        // one byte per write
         end
      end
   end

endmodule

`default_nettype wire

//--- hw/snd_wave_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "gb_sound_defs.svh"

module snd_wave_ram (
   input  logic                     ac97_bitclk,
   input  logic                     reset,
   input  snd_map_pkg::wave_sel_t   wave_sel,
   input  snd_field_pkg::reg_byte_t reg_data,
   output snd_field_pkg::wave_vec_t ch3_samples
);
   import snd_field_pkg::*;

   reg_byte_t wave_mem [`SND_WAVE_BYTES];  // FF30 at index 0

   always_ff @(posedge ac97_bitclk or posedge reset) begin
      if (reset) begin
         for (int i = 0; i < `SND_WAVE_BYTES; i++)
            wave_mem[i] <= '0;
      end else begin
         for (int i = 0; i < `SND_WAVE_BYTES; i++) begin
            if (wave_sel[i])
               wave_mem[i] <= reg_data;
         end
      end
   end

   // FF30 lands in the top byte, sample zero plays first
   always_comb begin
      for (int i = 0; i < `SND_WAVE_BYTES; i++)
         ch3_samples[(`SND_WAVE_BYTES-i)*`SND_BYTE_W-1 -: `SND_BYTE_W] = wave_mem[i];
   end

endmodule

`default_nettype wire

//--- hw/snd_master_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "gb_sound_defs.svh"

module snd_master_ctrl (
   input  logic                       ac97_bitclk,
   input  logic                       reset,
   input  snd_map_pkg::ctrl_sel_t     ctrl_sel,
   input  snd_field_pkg::reg_byte_t   reg_data,
   output logic                       so2_vin,
   output snd_field_pkg::master_vol_t so2_output_level,
   output logic                       so1_vin,
   output snd_field_pkg::master_vol_t so1_output_level,
   output logic [`SND_NUM_CH-1:0]     so2_ch_enable,     // bit i is channel i+1
   output logic [`SND_NUM_CH-1:0]     so1_ch_enable,
   output logic                       master_sound_enable,
   output logic [`SND_NUM_CH-1:0]     ch_on_flag
);
   import snd_field_pkg::*;
   import snd_map_pkg::*;

   reg_byte_t nr50, nr51, nr52;

   always_ff @(posedge ac97_bitclk or posedge reset) begin
      if (reset) begin
         nr50 <= '0;
         nr51 <= '0;
         nr52 <= '0;
      end else begin
         if (ctrl_sel[CTRL_NR50]) nr50 <= reg_data;
         if (ctrl_sel[CTRL_NR51]) nr51 <= reg_data;
         if (ctrl_sel[CTRL_NR52]) nr52 <= reg_data;  // flags kept as written
      end
   end

   assign so2_vin             = nr50[7];
   assign so2_output_level    = nr50[6:4];
   assign so1_vin             = nr50[3];
   assign so1_output_level    = nr50[2:0];
   assign so2_ch_enable       = nr51[7:4];   // upper nibble routes to SO2
   assign so1_ch_enable       = nr51[3:0];
   assign master_sound_enable = nr52[7];
   assign ch_on_flag          = nr52[3:0];   // bits 6..4 not used

endmodule

`default_nettype wire

//--- hw/snd_field_unpack.sv
`timescale 1ns/1ps
`default_nettype none

`include "gb_sound_defs.svh"

module snd_field_unpack (
   input  snd_field_pkg::reg_byte_t [`SND_CH_STRIDE-1:0] bank0_bytes,  // NR10..NR14
   input  snd_field_pkg::reg_byte_t [`SND_CH_STRIDE-1:0] bank1_bytes,  // FF15, NR21..NR24
   input  snd_field_pkg::reg_byte_t [`SND_CH_STRIDE-1:0] bank2_bytes,  // NR30..NR34
   input  snd_field_pkg::reg_byte_t [`SND_CH_STRIDE-1:0] bank3_bytes,  // FF1F, NR41..NR44
   output snd_field_pkg::steps_t     ch1_sweep_time,
   output logic                      ch1_sweep_decreasing,
   output snd_field_pkg::steps_t     ch1_num_sweep_shifts,
   output snd_field_pkg::duty_t      ch1_wave_duty,
   output snd_field_pkg::length6_t   ch1_length_data,
   output snd_field_pkg::volume_t    ch1_initial_volume,
   output logic                      ch1_envelope_increasing,
   output snd_field_pkg::steps_t     ch1_num_envelope_sweeps,
   output logic                      ch1_reset,
   output logic                      ch1_dont_loop,
   output snd_field_pkg::freq_t      ch1_frequency_data,
   output snd_field_pkg::duty_t      ch2_wave_duty,
   output snd_field_pkg::length6_t   ch2_length_data,
   output snd_field_pkg::volume_t    ch2_initial_volume,
   output logic                      ch2_envelope_increasing,
   output snd_field_pkg::steps_t     ch2_num_envelope_sweeps,
   output logic                      ch2_reset,
   output logic                      ch2_dont_loop,
   output snd_field_pkg::freq_t      ch2_frequency_data,
   output logic                      ch3_enable,
   output snd_field_pkg::length8_t   ch3_length_data,
   output snd_field_pkg::out_level_t ch3_output_level,
   output logic                      ch3_reset,
   output logic                      ch3_dont_loop,
   output snd_field_pkg::freq_t      ch3_frequency_data,
   output snd_field_pkg::length6_t   ch4_length_data,
   output snd_field_pkg::volume_t    ch4_initial_volume,
   output logic                      ch4_envelope_increasing,
   output snd_field_pkg::steps_t     ch4_num_envelope_sweeps,
   output logic [3:0]                ch4_shift_clock_freq_data,
   output logic                      ch4_counter_width,
   output logic [2:0]                ch4_freq_dividing_ratio,
   output logic                      ch4_reset,
   output logic                      ch4_dont_loop
);
   import snd_map_pkg::*;

   // tone and sweep
   assign ch1_sweep_time          = bank0_bytes[OFS_NRX0][6:4];
   assign ch1_sweep_decreasing    = bank0_bytes[OFS_NRX0][3];
   assign ch1_num_sweep_shifts    = bank0_bytes[OFS_NRX0][2:0];
   assign ch1_wave_duty           = bank0_bytes[OFS_NRX1][7:6];
   assign ch1_length_data         = bank0_bytes[OFS_NRX1][5:0];
   assign ch1_initial_volume      = bank0_bytes[OFS_NRX2][7:4];
   assign ch1_envelope_increasing = bank0_bytes[OFS_NRX2][3];
   assign ch1_num_envelope_sweeps = bank0_bytes[OFS_NRX2][2:0];
   assign ch1_reset               = bank0_bytes[OFS_NRX4][7];   // initial bit
   assign ch1_dont_loop           = bank0_bytes[OFS_NRX4][6];   // length enable
   assign ch1_frequency_data      = {bank0_bytes[OFS_NRX4][2:0], bank0_bytes[OFS_NRX3]};

   // tone, offset 0 has no register
   assign ch2_wave_duty           = bank1_bytes[OFS_NRX1][7:6];
   assign ch2_length_data         = bank1_bytes[OFS_NRX1][5:0];
   assign ch2_initial_volume      = bank1_bytes[OFS_NRX2][7:4];
   assign ch2_envelope_increasing = bank1_bytes[OFS_NRX2][3];
   assign ch2_num_envelope_sweeps = bank1_bytes[OFS_NRX2][2:0];
   assign ch2_reset               = bank1_bytes[OFS_NRX4][7];
   assign ch2_dont_loop           = bank1_bytes[OFS_NRX4][6];
   assign ch2_frequency_data      = {bank1_bytes[OFS_NRX4][2:0], bank1_bytes[OFS_NRX3]};

   // wave output
   assign ch3_enable              = bank2_bytes[OFS_NRX0][7];   // playback on
   assign ch3_length_data         = bank2_bytes[OFS_NRX1];
   assign ch3_output_level        = bank2_bytes[OFS_NRX2][6:5];
   assign ch3_reset               = bank2_bytes[OFS_NRX4][7];
   assign ch3_dont_loop           = bank2_bytes[OFS_NRX4][6];
   assign ch3_frequency_data      = {bank2_bytes[OFS_NRX4][2:0], bank2_bytes[OFS_NRX3]};

   // noise, offset 0 is the FF1F hole
   assign ch4_length_data           = bank3_bytes[OFS_NRX1][5:0];
   assign ch4_initial_volume        = bank3_bytes[OFS_NRX2][7:4];
   assign ch4_envelope_increasing   = bank3_bytes[OFS_NRX2][3];
   assign ch4_num_envelope_sweeps   = bank3_bytes[OFS_NRX2][2:0];
   assign ch4_shift_clock_freq_data = bank3_bytes[OFS_NRX3][7:4];  // s
   assign ch4_counter_width         = bank3_bytes[OFS_NRX3][3];    // 1 = 7 bit lfsr
   assign ch4_freq_dividing_ratio   = bank3_bytes[OFS_NRX3][2:0];  // r
   assign ch4_reset                 = bank3_bytes[OFS_NRX4][7];
   assign ch4_dont_loop             = bank3_bytes[OFS_NRX4][6];

endmodule

`default_nettype wire

//--- hw/snd_regs_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "gb_sound_defs.svh"

module snd_regs_top (
   input  logic                       ac97_bitclk,
   input  logic                       reset,
   input  snd_field_pkg::bus_addr_t   reg_addr,
   input  snd_field_pkg::reg_byte_t   reg_data,
   input  logic                       reg_w_enable,
   output snd_field_pkg::steps_t      ch1_sweep_time,
   output logic                       ch1_sweep_decreasing,
   output snd_field_pkg::steps_t      ch1_num_sweep_shifts,
   output snd_field_pkg::duty_t       ch1_wave_duty,
   output snd_field_pkg::length6_t    ch1_length_data,
   output snd_field_pkg::volume_t     ch1_initial_volume,
   output logic                       ch1_envelope_increasing,
   output snd_field_pkg::steps_t      ch1_num_envelope_sweeps,
   output logic                       ch1_reset,
   output logic                       ch1_dont_loop,
   output snd_field_pkg::freq_t       ch1_frequency_data,
   output snd_field_pkg::duty_t       ch2_wave_duty,
   output snd_field_pkg::length6_t    ch2_length_data,
   output snd_field_pkg::volume_t     ch2_initial_volume,
   output logic                       ch2_envelope_increasing,
   output snd_field_pkg::steps_t      ch2_num_envelope_sweeps,
   output logic                       ch2_reset,
   output logic                       ch2_dont_loop,
   output snd_field_pkg::freq_t       ch2_frequency_data,
   output logic                       ch3_enable,
   output snd_field_pkg::length8_t    ch3_length_data,
   output snd_field_pkg::out_level_t  ch3_output_level,
   output logic                       ch3_reset,
   output logic                       ch3_dont_loop,
   output snd_field_pkg::freq_t       ch3_frequency_data,
   output snd_field_pkg::wave_vec_t   ch3_samples,
   output snd_field_pkg::length6_t    ch4_length_data,
   output snd_field_pkg::volume_t     ch4_initial_volume,
   output logic                       ch4_envelope_increasing,
   output snd_field_pkg::steps_t      ch4_num_envelope_sweeps,
   output logic [3:0]                 ch4_shift_clock_freq_data,
   output logic                       ch4_counter_width,
   output logic [2:0]                 ch4_freq_dividing_ratio,
   output logic                       ch4_reset,
   output logic                       ch4_dont_loop,
   output logic                       so2_vin,
   output snd_field_pkg::master_vol_t so2_output_level,
   output logic                       so1_vin,
   output snd_field_pkg::master_vol_t so1_output_level,
   output logic                       so2_ch4_enable,
   output logic                       so2_ch3_enable,
   output logic                       so2_ch2_enable,
   output logic                       so2_ch1_enable,
   output logic                       so1_ch4_enable,
   output logic                       so1_ch3_enable,
   output logic                       so1_ch2_enable,
   output logic                       so1_ch1_enable,
   output logic                       master_sound_enable,
   output logic                       ch4_on_flag,
   output logic                       ch3_on_flag,
   output logic                       ch2_on_flag,
   output logic                       ch1_on_flag
);
   import snd_field_pkg::*;
   import snd_map_pkg::*;

   ch_sel_t   ch_sel;
   bank_be_t  bank_be;
   wave_sel_t wave_sel;
   ctrl_sel_t ctrl_sel;

   reg_byte_t [`SND_CH_STRIDE-1:0] bank_bytes [`SND_NUM_CH];  // one window per channel

   logic [`SND_NUM_CH-1:0] so2_ch_enable, so1_ch_enable, ch_on_flag;

   snd_addr_decode snd_addr_decode_inst (
      .reg_addr, .reg_w_enable, .ch_sel, .bank_be, .wave_sel, .ctrl_sel
   );

   // FF10, FF15, FF1A, FF1F windows
   for (genvar i = 0; i < `SND_NUM_CH; i++) begin : ch_bank
      snd_channel_bank snd_channel_bank_inst (
         .ac97_bitclk, .reset,
         .ch_en      (ch_sel[i]),
         .bank_be,
         .reg_data,
         .bank_bytes (bank_bytes[i])
      );
   end

   snd_field_unpack snd_field_unpack_inst (
      .bank0_bytes (bank_bytes[0]),
      .bank1_bytes (bank_bytes[1]),
      .bank2_bytes (bank_bytes[2]),
      .bank3_bytes (bank_bytes[3]),
      .ch1_sweep_time, .ch1_sweep_decreasing, .ch1_num_sweep_shifts,
      .ch1_wave_duty, .ch1_length_data, .ch1_initial_volume,
      .ch1_envelope_increasing, .ch1_num_envelope_sweeps,
      .ch1_reset, .ch1_dont_loop, .ch1_frequency_data,
      .ch2_wave_duty, .ch2_length_data, .ch2_initial_volume,
      .ch2_envelope_increasing, .ch2_num_envelope_sweeps,
      .ch2_reset, .ch2_dont_loop, .ch2_frequency_data,
      .ch3_enable, .ch3_length_data, .ch3_output_level,
      .ch3_reset, .ch3_dont_loop, .ch3_frequency_data,
      .ch4_length_data, .ch4_initial_volume, .ch4_envelope_increasing,
      .ch4_num_envelope_sweeps, .ch4_shift_clock_freq_data,
      .ch4_counter_width, .ch4_freq_dividing_ratio,
      .ch4_reset, .ch4_dont_loop
   );

   snd_wave_ram snd_wave_ram_inst (
      .ac97_bitclk, .reset, .wave_sel, .reg_data, .ch3_samples
   );

   snd_master_ctrl snd_master_ctrl_inst (
      .ac97_bitclk, .reset, .ctrl_sel, .reg_data,
      .so2_vin, .so2_output_level, .so1_vin, .so1_output_level,
      .so2_ch_enable, .so1_ch_enable, .master_sound_enable, .ch_on_flag
   );

   // fan the NR51/NR52 nibbles out to per-channel ports
   assign {so2_ch4_enable, so2_ch3_enable, so2_ch2_enable, so2_ch1_enable} = so2_ch_enable;
   assign {so1_ch4_enable, so1_ch3_enable, so1_ch2_enable, so1_ch1_enable} = so1_ch_enable;
   assign {ch4_on_flag, ch3_on_flag, ch2_on_flag, ch1_on_flag}             = ch_on_flag;

endmodule

`default_nettype wire

//--- dv/snd_regs_assert.sv
`timescale 1ns/1ps
`default_nettype none

`include "gb_sound_defs.svh"

module snd_regs_assert (
   input logic                       ac97_bitclk,
   input logic                       reset,
   input logic                       reg_w_enable,
   input snd_map_pkg::ch_sel_t       ch_sel,
   input snd_map_pkg::bank_be_t      bank_be,
   input snd_map_pkg::wave_sel_t     wave_sel,
   input snd_map_pkg::ctrl_sel_t     ctrl_sel,
   input snd_field_pkg::reg_byte_t   [`SND_CH_STRIDE-1:0] bank_bytes [`SND_NUM_CH],
   input snd_field_pkg::wave_vec_t   ch3_samples,
   input logic                       so2_vin,
   input snd_field_pkg::master_vol_t so2_output_level,
   input logic                       so1_vin,
   input snd_field_pkg::master_vol_t so1_output_level,
   input logic [`SND_NUM_CH-1:0]     so2_ch_enable,
   input logic [`SND_NUM_CH-1:0]     so1_ch_enable,
   input logic [`SND_NUM_CH-1:0]     ch_on_flag,
   input logic                       master_sound_enable
);

   logic [`SND_CH_STRIDE*8*`SND_NUM_CH+127+21:0] state_bits;  // all the outputs derive from
   int fail_count = 0;  // failed assertions so far

   assign state_bits = {bank_bytes[0], bank_bytes[1], bank_bytes[2], bank_bytes[3],
                        ch3_samples, so2_ch_enable, so1_ch_enable, ch_on_flag,
                        master_sound_enable,
                        so2_vin, so2_output_level, so1_vin, so1_output_level};

   zero_in_reset: assert property (@(posedge ac97_bitclk) reset |=> state_bits == '0)
      else begin
         $error("outputs not cleared while reset is high");
         fail_count++;
      end

   hold_without_write: assert property (@(posedge ac97_bitclk) disable iff (reset)
      !reg_w_enable |=> $stable(state_bits))
      else begin
         $error("outputs moved after a cycle with no write");
         fail_count++;
      end

   // one region per write, a byte enable only with a window hit
   onehot_enables: assert property (@(posedge ac97_bitclk) disable iff (reset)
      $onehot0({ch_sel, wave_sel, ctrl_sel}) &&
      ((ch_sel != '0) ? $onehot(bank_be) : (bank_be == '0)))
      else begin
         $error("more than one decoder enable high");
         fail_count++;
      end

endmodule

bind snd_regs_top snd_regs_assert snd_regs_assert_inst (.*);

`default_nettype wire

//--- dv/snd_regs_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "gb_sound_defs.svh"

module snd_regs_tb;
   import snd_field_pkg::*;

   localparam int RESET_CYCLES = 5;
   localparam int TABLE_LEN    = 31;
   localparam int NUM_RAND     = 200;
   localparam int CYCLE_LIMIT  = 2 * (TABLE_LEN + NUM_RAND + RESET_CYCLES);
   localparam logic [1:0] KIND_CH = 2'd0, KIND_WAVE = 2'd1, KIND_CTRL = 2'd2, KIND_ALL = 2'd3;

   typedef struct packed {
      bus_addr_t  addr;
      reg_byte_t  data;
      logic       wen;
      logic [1:0] kind;   // which output group to compare
   } entry_t;

   logic ac97_bitclk, reset, reg_w_enable;
   bus_addr_t reg_addr;
   reg_byte_t reg_data;
   steps_t ch1_sweep_time, ch1_num_sweep_shifts, ch1_num_envelope_sweeps;
   steps_t ch2_num_envelope_sweeps, ch4_num_envelope_sweeps;
   logic ch1_sweep_decreasing, ch1_envelope_increasing, ch1_reset, ch1_dont_loop;
   logic ch2_envelope_increasing, ch2_reset, ch2_dont_loop;
   logic ch3_enable, ch3_reset, ch3_dont_loop;
   logic ch4_envelope_increasing, ch4_counter_width, ch4_reset, ch4_dont_loop;
   duty_t ch1_wave_duty, ch2_wave_duty;
   length6_t ch1_length_data, ch2_length_data, ch4_length_data;
   length8_t ch3_length_data;
   volume_t ch1_initial_volume, ch2_initial_volume, ch4_initial_volume;
   freq_t ch1_frequency_data, ch2_frequency_data, ch3_frequency_data;
   out_level_t ch3_output_level;
   wave_vec_t ch3_samples;
   logic [3:0] ch4_shift_clock_freq_data;
   logic [2:0] ch4_freq_dividing_ratio;
   logic so2_vin, so1_vin, master_sound_enable;
   master_vol_t so2_output_level, so1_output_level;
   logic so2_ch4_enable, so2_ch3_enable, so2_ch2_enable, so2_ch1_enable;
   logic so1_ch4_enable, so1_ch3_enable, so1_ch2_enable, so1_ch1_enable;
   logic ch4_on_flag, ch3_on_flag, ch2_on_flag, ch1_on_flag;

   reg_byte_t   mdl [256];               // FF00..FFFF image
   entry_t      tbl [TABLE_LEN];
   logic [31:0] lfsr_state = 32'h6336;
   int          cycles     = 0;

   snd_regs_top snd_regs_top_inst (.*);

   initial begin
      ac97_bitclk = 1'b0;
      forever #2 ac97_bitclk = ~ac97_bitclk;   // 4 ns period
   end

   always @(posedge ac97_bitclk) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("Test failed");
         $fatal(1);
      end
   end

   // bound checker failures end the run as well
   always @(snd_regs_top_inst.snd_regs_assert_inst.fail_count) begin
      if (snd_regs_top_inst.snd_regs_assert_inst.fail_count != 0) begin
         $display("a bound assertion on the DUT failed");
         $display("Test failed");
         $fatal(1);
      end
   end

   // taps 32, 22, 2, 1
   function automatic logic lfsr_bit();
      logic fb;
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      return fb;
   endfunction

   function automatic logic [7:0] lfsr_bits(input int n);
      logic [7:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
         v = {v[6:0], lfsr_bit()};
      return v;
   endfunction

   task automatic mismatch(input string name, input logic [127:0] exp, input logic [127:0] act);
      $display("ERROR t=%0t %s expected %0h actual %0h", $time, name, exp, act);
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic check_freq(input string name, input freq_t exp, input freq_t act);
      if (act !== exp) mismatch(name, exp, act);
   endtask

   task automatic check_byte_field(input string name, input reg_byte_t exp, input reg_byte_t act);
      if (act !== exp) mismatch(name, exp, act);
   endtask

   task automatic check_samples(input string name, input wave_vec_t exp, input wave_vec_t act);
      if (act !== exp) mismatch(name, exp, act);
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) mismatch(name, exp, act);
   endtask

   task automatic check_channels();
      check_byte_field("ch1_sweep_time", mdl[8'h10][6:4], ch1_sweep_time);
      check_flag("ch1_sweep_decreasing", mdl[8'h10][3], ch1_sweep_decreasing);
      check_byte_field("ch1_num_sweep_shifts", mdl[8'h10][2:0], ch1_num_sweep_shifts);
      check_byte_field("ch1_wave_duty", mdl[8'h11][7:6], ch1_wave_duty);
      check_byte_field("ch1_length_data", mdl[8'h11][5:0], ch1_length_data);
      check_byte_field("ch1_initial_volume", mdl[8'h12][7:4], ch1_initial_volume);
      check_flag("ch1_envelope_increasing", mdl[8'h12][3], ch1_envelope_increasing);
      check_byte_field("ch1_num_envelope_sweeps", mdl[8'h12][2:0], ch1_num_envelope_sweeps);
      check_flag("ch1_reset", mdl[8'h14][7], ch1_reset);
      check_flag("ch1_dont_loop", mdl[8'h14][6], ch1_dont_loop);
      check_freq("ch1_frequency_data", {mdl[8'h14][2:0], mdl[8'h13]}, ch1_frequency_data);
      check_byte_field("ch2_wave_duty", mdl[8'h16][7:6], ch2_wave_duty);
      check_byte_field("ch2_length_data", mdl[8'h16][5:0], ch2_length_data);
      check_byte_field("ch2_initial_volume", mdl[8'h17][7:4], ch2_initial_volume);
      check_flag("ch2_envelope_increasing", mdl[8'h17][3], ch2_envelope_increasing);
      check_byte_field("ch2_num_envelope_sweeps", mdl[8'h17][2:0], ch2_num_envelope_sweeps);
      check_flag("ch2_reset", mdl[8'h19][7], ch2_reset);
      check_flag("ch2_dont_loop", mdl[8'h19][6], ch2_dont_loop);
      check_freq("ch2_frequency_data", {mdl[8'h19][2:0], mdl[8'h18]}, ch2_frequency_data);
      check_flag("ch3_enable", mdl[8'h1A][7], ch3_enable);
      check_byte_field("ch3_length_data", mdl[8'h1B], ch3_length_data);
      check_byte_field("ch3_output_level", mdl[8'h1C][6:5], ch3_output_level);
      check_flag("ch3_reset", mdl[8'h1E][7], ch3_reset);
      check_flag("ch3_dont_loop", mdl[8'h1E][6], ch3_dont_loop);
      check_freq("ch3_frequency_data", {mdl[8'h1E][2:0], mdl[8'h1D]}, ch3_frequency_data);
      check_byte_field("ch4_length_data", mdl[8'h20][5:0], ch4_length_data);
      check_byte_field("ch4_initial_volume", mdl[8'h21][7:4], ch4_initial_volume);
      check_flag("ch4_envelope_increasing", mdl[8'h21][3], ch4_envelope_increasing);
      check_byte_field("ch4_num_envelope_sweeps", mdl[8'h21][2:0], ch4_num_envelope_sweeps);
      check_byte_field("ch4_shift_clock_freq_data", mdl[8'h22][7:4], ch4_shift_clock_freq_data);
      check_flag("ch4_counter_width", mdl[8'h22][3], ch4_counter_width);
      check_byte_field("ch4_freq_dividing_ratio", mdl[8'h22][2:0], ch4_freq_dividing_ratio);
      check_flag("ch4_reset", mdl[8'h23][7], ch4_reset);
      check_flag("ch4_dont_loop", mdl[8'h23][6], ch4_dont_loop);
   endtask

   task automatic check_wave();
      wave_vec_t exp;
      for (int i = 0; i < `SND_WAVE_BYTES; i++)
         exp[127-8*i -: 8] = mdl[8'h30 + i];   // FF30 on top
      check_samples("ch3_samples", exp, ch3_samples);
   endtask

   task automatic check_ctrl();
      check_flag("so2_vin", mdl[8'h24][7], so2_vin);
      check_byte_field("so2_output_level", mdl[8'h24][6:4], so2_output_level);
      check_flag("so1_vin", mdl[8'h24][3], so1_vin);
      check_byte_field("so1_output_level", mdl[8'h24][2:0], so1_output_level);
      check_byte_field("so2_ch_enable", mdl[8'h25][7:4],
                       {so2_ch4_enable, so2_ch3_enable, so2_ch2_enable, so2_ch1_enable});
      check_byte_field("so1_ch_enable", mdl[8'h25][3:0],
                       {so1_ch4_enable, so1_ch3_enable, so1_ch2_enable, so1_ch1_enable});
      check_flag("master_sound_enable", mdl[8'h26][7], master_sound_enable);
      check_byte_field("ch_on_flag", mdl[8'h26][3:0],
                       {ch4_on_flag, ch3_on_flag, ch2_on_flag, ch1_on_flag});
   endtask

   task automatic check_outputs(input logic [1:0] kind);
      if (kind == KIND_CH || kind == KIND_ALL) check_channels();
      if (kind == KIND_WAVE || kind == KIND_ALL) check_wave();
      if (kind == KIND_CTRL || kind == KIND_ALL) check_ctrl();
   endtask

   // drive on one edge, the DUT takes it on the next, compare at the falling edge
   task automatic apply_write(input entry_t e);
      @(posedge ac97_bitclk);
      reg_addr     <= e.addr;
      reg_data     <= e.data;
      reg_w_enable <= e.wen;
      if (e.wen && e.addr[15:8] == 8'hFF &&
          ((e.addr[7:0] >= 8'h10 && e.addr[7:0] <= 8'h26) ||
           (e.addr[7:0] >= 8'h30 && e.addr[7:0] <= 8'h3F)))
         mdl[e.addr[7:0]] = e.data;
      @(posedge ac97_bitclk);
      @(negedge ac97_bitclk);
      check_outputs(e.kind);
   endtask

   initial begin
      entry_t e;
      reset        = 1'b1;
      reg_w_enable = 1'b0;
      reg_addr     = '0;
      reg_data     = '0;
      for (int i = 0; i < 256; i++)
         mdl[i] = '0;
      tbl = '{
         '{16'hFF10, 8'h5A, 1'b1, KIND_CH},   '{16'hFF11, 8'hC7, 1'b1, KIND_CH},
         '{16'hFF12, 8'hF3, 1'b1, KIND_CH},   '{16'hFF13, 8'hAB, 1'b1, KIND_CH},
         '{16'hFF14, 8'hC5, 1'b1, KIND_CH},   '{16'hFF16, 8'h81, 1'b1, KIND_CH},
         '{16'hFF17, 8'h2E, 1'b1, KIND_CH},   '{16'hFF18, 8'h34, 1'b1, KIND_CH},
         '{16'hFF19, 8'h86, 1'b1, KIND_CH},   '{16'hFF1A, 8'h80, 1'b1, KIND_CH},
         '{16'hFF1B, 8'hFF, 1'b1, KIND_CH},   '{16'hFF1C, 8'h60, 1'b1, KIND_CH},
         '{16'hFF1D, 8'h12, 1'b1, KIND_CH},   '{16'hFF1E, 8'h47, 1'b1, KIND_CH},
         '{16'hFF30, 8'h01, 1'b1, KIND_WAVE}, '{16'hFF31, 8'h23, 1'b1, KIND_WAVE},
         '{16'hFF3F, 8'hEF, 1'b1, KIND_WAVE}, '{16'hFF20, 8'h3F, 1'b1, KIND_CH},
         '{16'hFF21, 8'hA9, 1'b1, KIND_CH},   '{16'hFF22, 8'h5B, 1'b1, KIND_CH},
         '{16'hFF23, 8'hC0, 1'b1, KIND_CH},   '{16'hFF24, 8'hF7, 1'b1, KIND_CTRL},
         '{16'hFF25, 8'hA5, 1'b1, KIND_CTRL}, '{16'hFF26, 8'h8B, 1'b1, KIND_CTRL},
         '{16'hFF15, 8'hAA, 1'b1, KIND_ALL},  '{16'hFF1F, 8'h55, 1'b1, KIND_ALL},  // holes
         '{16'hFF27, 8'hFF, 1'b1, KIND_ALL},  '{16'hFF40, 8'hFF, 1'b1, KIND_ALL},
         '{16'h0000, 8'hFF, 1'b1, KIND_ALL},  '{16'hFF10, 8'h00, 1'b0, KIND_ALL},  // strobe low
         '{16'hFF30, 8'hFF, 1'b0, KIND_ALL}
      };
      repeat (RESET_CYCLES) @(posedge ac97_bitclk);
      reset <= 1'b0;
      @(negedge ac97_bitclk);
      check_outputs(KIND_ALL);   // all clear after reset
      foreach (tbl[i])
         apply_write(tbl[i]);
      for (int k = 0; k < NUM_RAND; k++) begin
         e.addr = 16'hFF10 + bus_addr_t'(lfsr_bits(6) % 48);   // FF10..FF3F
         e.data = lfsr_bits(8);
         e.wen  = 1'b1;
         e.kind = KIND_ALL;
         apply_write(e);
      end
      $display("Test completed successfully");
      $finish;
   end

endmodule

`default_nettype wire

//--- project.f
+incdir+hw
hw/snd_field_pkg.sv
hw/snd_map_pkg.sv
hw/snd_addr_decode.sv
hw/snd_channel_bank.sv
hw/snd_wave_ram.sv
hw/snd_master_ctrl.sv
hw/snd_field_unpack.sv
hw/snd_regs_top.sv
dv/snd_regs_assert.sv
dv/snd_regs_tb.sv
